// File: src/icache_geom_pkg.sv
package icache_geom_pkg;

    // organisation
    localparam int NUM_WAYS          = 2;
    localparam int INDEX_WIDTH       = 6;
    localparam int LINE_OFFSET_WIDTH = 6;
    localparam int TAG_WIDTH         = 32 - INDEX_WIDTH - LINE_OFFSET_WIDTH;
    localparam int SET_NUM           = 1 << INDEX_WIDTH;

    // line and fetch word sizes in bits
    localparam int LINE_BITS         = 8 << LINE_OFFSET_WIDTH;
    localparam int FETCH_BITS        = 64;
    localparam int FETCH_SEL_WIDTH   = 3;

    // memory length codes, n means n+1 beats
    localparam int LINE_BURST_LEN     = 15;
    localparam int UNCACHED_BURST_LEN = 1;

    typedef logic [INDEX_WIDTH-1:0] index_t;
    typedef logic [TAG_WIDTH-1:0]   tag_t;
    typedef logic [LINE_BITS-1:0]   line_t;
    typedef logic [FETCH_BITS-1:0]  fetch_t;
    typedef logic [NUM_WAYS-1:0]    way_vec_t;

endpackage

// File: src/icache_ops_pkg.sv
package icache_ops_pkg;

    // main controller states
    typedef enum logic [2:0] {
        IDLE   = 3'd0,
        LOOKUP = 3'd1,
        MISS   = 3'd2,
        REFILL = 3'd3,
        CACOP  = 3'd4
    } cache_state_e;

    // cache operation codes as issued by the pipeline
    typedef enum logic [1:0] {
        STORE_TAG        = 2'd0,
        INDEX_INVALIDATE = 2'd1,
        HIT_INVALIDATE   = 2'd2
    } cacop_code_e;

    typedef logic [6:0] exc_code_t;

    localparam exc_code_t EXC_NONE = 7'h00;
    // fetch address not word aligned
    localparam exc_code_t EXC_ADEF = 7'h08;

    // andi r0, r0, 0
    localparam logic [31:0] INST_NOP = 32'h0340_0000;

endpackage

// File: src/icache_way.sv
`timescale 1ns/100ps

module icache_way
    import icache_geom_pkg::*;
(
    input  logic   i_clk,
    input  logic   i_rstn,
    input  index_t i_rindex,
    input  tag_t   i_lookup_tag,
    input  logic   i_we,
    input  logic   i_clear,
    input  index_t i_windex,
    input  tag_t   i_wtag,
    input  line_t  i_wline,
    output logic   o_hit,
    output line_t  o_line
);

    logic [SET_NUM-1:0] valid;
    tag_t               tag_mem  [SET_NUM];
    line_t              line_mem [SET_NUM];

    // read port registers
    logic valid_rd;
    tag_t tag_rd;

    // valid bits carry the reset
    always_ff @(posedge i_clk) begin
        if (!i_rstn) begin
            valid    <= '0;
            valid_rd <= 1'b0;
        end else begin
            valid_rd <= valid[i_rindex];
            if (i_we) begin
                valid[i_windex] <= !i_clear;
            end
        end
    end

    // tag and data arrays
    always_ff @(posedge i_clk) begin
        tag_rd <= tag_mem[i_rindex];
        o_line <= line_mem[i_rindex];
        if (i_we && !i_clear) begin
            tag_mem[i_windex]  <= i_wtag;
            line_mem[i_windex] <= i_wline;
        end
    end

    assign o_hit = valid_rd && (tag_rd == i_lookup_tag);

endmodule

// File: src/icache_ctrl.sv
`timescale 1ns/100ps

module icache_ctrl
    import icache_geom_pkg::*;
    import icache_ops_pkg::*;
(
    input  logic                       clk,
    input  logic                       rstn,
    input  logic                       i_rvalid,
    input  logic [31:0]                i_raddr,
    input  logic                       i_uncache,
    input  logic                       i_cacop_en,
    input  cacop_code_e                i_cacop_code,
    input  logic                       i_mem_rready,
    input  line_t                      i_mem_rdata,
    input  way_vec_t                   i_way_hit,
    output logic                       o_rready,
    output logic                       o_idle,
    output logic                       o_mem_rvalid,
    output logic [31:0]                o_mem_raddr,
    output logic [7:0]                 o_mem_rlen,
    output logic                       o_cacop_ready,
    output logic                       o_cacop_complete,
    output index_t                     o_rindex,
    output tag_t                       o_lookup_tag,
    output index_t                     o_windex,
    output tag_t                       o_wtag,
    output way_vec_t                   o_way_we,
    output logic                       o_clear,
    output line_t                      o_ret_line,
    output logic [FETCH_SEL_WIDTH-1:0] o_fetch_sel,
    output logic                       o_use_ret,
    output exc_code_t                  o_exception,
    output logic [31:0]                o_req_addr
);

    cache_state_e       state;
    cache_state_e       next_state;
    logic [31:0]        req_addr;
    logic               uncache_q;
    logic               cacop_q;
    cacop_code_e        cacop_code_q;
    line_t              ret_line;
    logic [SET_NUM-1:0] lru;
    logic               cacop_done_q;
    index_t             req_index;
    logic               accept;
    logic               lookup_hit;
    logic               lookup_done;
    way_vec_t           refill_way;
    way_vec_t           cacop_way;
    exc_code_t          exception;

    assign req_index  = req_addr[LINE_OFFSET_WIDTH +: INDEX_WIDTH];
    assign accept     = (state == IDLE) && (i_cacop_en || i_rvalid);
    assign lookup_hit = |i_way_hit && !uncache_q;
    assign exception  = (!cacop_q && req_addr[1:0] != 2'b00) ? EXC_ADEF : EXC_NONE;
    // a lookup ends here on a hit or a bad address
    assign lookup_done = (exception != EXC_NONE) || lookup_hit;

    // lru bit names the way to replace next
    assign refill_way = way_vec_t'(1) << lru[req_index];
    // index ops pick the way with address bit 0
    assign cacop_way  = (cacop_code_q == HIT_INVALIDATE) ? i_way_hit
                                                         : way_vec_t'(1) << req_addr[0];

    always_comb begin
        next_state = state;
        case (state)
            IDLE: begin
                if (i_cacop_en) begin
                    next_state = CACOP;
                end else if (i_rvalid) begin
                    next_state = LOOKUP;
                end
            end
            LOOKUP:  next_state = lookup_done ? IDLE : MISS;
            MISS:    next_state = i_mem_rready ? REFILL : MISS;
            REFILL:  next_state = IDLE;
            CACOP:   next_state = IDLE;
            default: next_state = IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            state        <= IDLE;
            uncache_q    <= 1'b0;
            cacop_q      <= 1'b0;
            cacop_done_q <= 1'b0;
        end else begin
            state        <= next_state;
            cacop_done_q <= (state == CACOP);
            if (accept) begin
                uncache_q <= i_uncache && !i_cacop_en;
                cacop_q   <= i_cacop_en;
            end
        end
    end

    // point away from the way just used
    always_ff @(posedge clk) begin
        if (!rstn) begin
            lru <= '0;
        end else if (state == LOOKUP && exception == EXC_NONE && lookup_hit) begin
            lru[req_index] <= !i_way_hit[1];
        end else if (state == REFILL && !uncache_q) begin
            lru[req_index] <= !lru[req_index];
        end
    end

    // request and return buffers
    always_ff @(posedge clk) begin
        if (accept) begin
            req_addr     <= i_raddr;
            cacop_code_q <= i_cacop_code;
        end
        if (state == MISS && i_mem_rready) begin
            ret_line <= i_mem_rdata;
        end
    end

    always_comb begin
        o_way_we = '0;
        if (state == REFILL && !uncache_q) begin
            o_way_we = refill_way;
        end else if (state == CACOP) begin
            o_way_we = cacop_way;
        end
    end

    assign o_rready         = (state == LOOKUP && lookup_done) || (state == REFILL);
    assign o_idle           = (state == IDLE);
    assign o_mem_rvalid     = (state == MISS);
    assign o_mem_raddr      = uncache_q ? {req_addr[31:3], 3'b000}
                                        : {req_addr[31:LINE_OFFSET_WIDTH],
                                           {LINE_OFFSET_WIDTH{1'b0}}};
    assign o_mem_rlen       = uncache_q ? 8'(UNCACHED_BURST_LEN) : 8'(LINE_BURST_LEN);
    assign o_cacop_ready    = (state == IDLE) && i_cacop_en;
    assign o_cacop_complete = cacop_done_q;

    // hold the read index so way outputs stay put after acceptance
    assign o_rindex     = (state == IDLE) ? i_raddr[LINE_OFFSET_WIDTH +: INDEX_WIDTH]
                                          : req_index;
    assign o_lookup_tag = req_addr[31 -: TAG_WIDTH];
    assign o_windex     = req_index;
    assign o_wtag       = req_addr[31 -: TAG_WIDTH];
    assign o_clear      = (state == CACOP);
    assign o_ret_line   = ret_line;
    // uncached data sits in the lowest slot
    assign o_fetch_sel  = uncache_q ? '0 : req_addr[LINE_OFFSET_WIDTH-1 -: FETCH_SEL_WIDTH];
    assign o_use_ret    = (state == REFILL);
    assign o_exception  = exception;
    assign o_req_addr   = req_addr;

endmodule

// File: src/icache_out_select.sv
`timescale 1ns/100ps

module icache_out_select
    import icache_geom_pkg::*;
    import icache_ops_pkg::*;
(
    input  way_vec_t                   i_way_hit,
    input  line_t                      i_way_line [NUM_WAYS],
    input  line_t                      i_ret_line,
    input  logic                       i_use_ret,
    input  logic [FETCH_SEL_WIDTH-1:0] i_fetch_sel,
    input  exc_code_t                  i_exception,
    input  logic [31:0]                i_req_addr,
    output fetch_t                     o_rdata,
    output logic [31:0]                o_badv
);

    line_t  hit_line;
    line_t  src_line;
    fetch_t slot;

    // at most one way hits, so an or-merge is enough
    always_comb begin
        hit_line = '0;
        for (int w = 0; w < NUM_WAYS; w++) begin
            if (i_way_hit[w]) begin
                hit_line = hit_line | i_way_line[w];
            end
        end
    end

    assign src_line = i_use_ret ? i_ret_line : hit_line;
    assign slot     = src_line[i_fetch_sel*FETCH_BITS +: FETCH_BITS];

    // bad fetch returns two nops
    assign o_rdata  = (i_exception != EXC_NONE) ? {INST_NOP, INST_NOP} : slot;
    assign o_badv   = (i_exception != EXC_NONE) ? i_req_addr : 32'h0;

endmodule

// File: src/icache.sv
`timescale 1ns/100ps

module icache
    import icache_geom_pkg::*;
    import icache_ops_pkg::*;
(
    input  logic        clk,
    input  logic        rstn,
    input  logic        i_rvalid,
    input  logic [31:0] i_raddr,
    input  logic        i_uncache,
    output logic        o_rready,
    output fetch_t      o_rdata,
    output exc_code_t   o_exception,
    output logic [31:0] o_badv,
    output logic        o_idle,
    output logic        o_mem_rvalid,
    output logic [31:0] o_mem_raddr,
    output logic [7:0]  o_mem_rlen,
    input  logic        i_mem_rready,
    input  line_t       i_mem_rdata,
    input  logic        i_cacop_en,
    input  cacop_code_e i_cacop_code,
    output logic        o_cacop_ready,
    output logic        o_cacop_complete
);

    index_t                     rindex;
    tag_t                       lookup_tag;
    index_t                     windex;
    tag_t                       wtag;
    way_vec_t                   way_we;
    logic                       clear;
    line_t                      ret_line;
    logic [FETCH_SEL_WIDTH-1:0] fetch_sel;
    logic                       use_ret;
    logic [31:0]                req_addr;
    way_vec_t                   way_hit;
    line_t                      way_line [NUM_WAYS];

    icache_ctrl ctrl_i (
        .clk              (clk),
        .rstn             (rstn),
        .i_rvalid         (i_rvalid),
        .i_raddr          (i_raddr),
        .i_uncache        (i_uncache),
        .i_cacop_en       (i_cacop_en),
        .i_cacop_code     (i_cacop_code),
        .i_mem_rready     (i_mem_rready),
        .i_mem_rdata      (i_mem_rdata),
        .i_way_hit        (way_hit),
        .o_rready         (o_rready),
        .o_idle           (o_idle),
        .o_mem_rvalid     (o_mem_rvalid),
        .o_mem_raddr      (o_mem_raddr),
        .o_mem_rlen       (o_mem_rlen),
        .o_cacop_ready    (o_cacop_ready),
        .o_cacop_complete (o_cacop_complete),
        .o_rindex         (rindex),
        .o_lookup_tag     (lookup_tag),
        .o_windex         (windex),
        .o_wtag           (wtag),
        .o_way_we         (way_we),
        .o_clear          (clear),
        .o_ret_line       (ret_line),
        .o_fetch_sel      (fetch_sel),
        .o_use_ret        (use_ret),
        .o_exception      (o_exception),
        .o_req_addr       (req_addr)
    );

    // identical ways on shared buses, one write enable each
    for (genvar w = 0; w < NUM_WAYS; w++) begin : g_way
        icache_way way_i (
            .i_clk        (clk),
            .i_rstn       (rstn),
            .i_rindex     (rindex),
            .i_lookup_tag (lookup_tag),
            .i_we         (way_we[w]),
            .i_clear      (clear),
            .i_windex     (windex),
            .i_wtag       (wtag),
            .i_wline      (ret_line),
            .o_hit        (way_hit[w]),
            .o_line       (way_line[w])
        );
    end

    icache_out_select out_sel_i (
        .i_way_hit   (way_hit),
        .i_way_line  (way_line),
        .i_ret_line  (ret_line),
        .i_use_ret   (use_ret),
        .i_fetch_sel (fetch_sel),
        .i_exception (o_exception),
        .i_req_addr  (req_addr),
        .o_rdata     (o_rdata),
        .o_badv      (o_badv)
    );

endmodule

// File: sim/icache_checker.sv
`timescale 1ns/100ps

module icache_checker
    import icache_geom_pkg::*;
    import icache_ops_pkg::*;
#(
    parameter logic [31:0] MEM_PATTERN = 32'h0
) (
    input  logic        clk,
    input  logic        rstn,
    input  logic        i_rvalid,
    input  logic [31:0] i_raddr,
    input  logic        i_uncache,
    input  logic        i_cacop_en,
    input  cacop_code_e i_cacop_code,
    input  logic        i_rready,
    input  fetch_t      i_rdata,
    input  exc_code_t   i_exception,
    input  logic [31:0] i_badv,
    input  logic        i_idle,
    input  logic        i_mem_rvalid,
    input  logic [31:0] i_mem_raddr,
    input  logic [7:0]  i_mem_rlen,
    input  logic        i_cacop_ready,
    input  logic        i_cacop_complete,
    output int          o_errors,
    output int          o_checks
);

    // reference copy of valid bits, tags and lru pointers
    logic        m_valid [NUM_WAYS][SET_NUM];
    tag_t        m_tag   [NUM_WAYS][SET_NUM];
    logic        m_lru   [SET_NUM];

    logic        fetch_pending;
    logic        cacop_pending;
    logic        cacop_busy;
    logic        exp_idle;
    logic        mem_seen;
    int          wait_cycles;
    logic        exp_miss;
    logic [31:0] exp_maddr;
    logic [7:0]  exp_mlen;
    fetch_t      exp_rdata;
    exc_code_t   exp_exc;
    logic [31:0] exp_badv;

    initial begin
        o_errors = 0;
        o_checks = 0;
    end

    task automatic compare_value(input string name, input logic [63:0] exp,
                                 input logic [63:0] got);
        o_checks++;
        if (got !== exp) begin
            $display("MISMATCH at %0t %s expected %h got %h", $time, name, exp, got);
            o_errors++;
        end
    endtask

    task automatic report_failure(input string what);
        $display("ERROR at %0t %s", $time, what);
        o_errors++;
    endtask

    // expected response and model update for one accepted fetch
    task automatic predict_fetch(input logic [31:0] addr, input logic unc);
        index_t      idx;
        tag_t        tg;
        int          hit_way;
        logic        victim;
        logic [31:0] word;
        idx     = addr[11:6];
        tg      = addr[31:12];
        hit_way = -1;
        for (int w = 0; w < NUM_WAYS; w++) begin
            if (m_valid[w][idx] && m_tag[w][idx] == tg) begin
                hit_way = w;
            end
        end
        // memory word address of the lower instruction
        word      = {addr[31:3], 3'b000} >> 2;
        exp_exc   = (addr[1:0] != 2'b00) ? EXC_ADEF : EXC_NONE;
        exp_badv  = (exp_exc != EXC_NONE) ? addr : 32'h0;
        exp_rdata = (exp_exc != EXC_NONE) ? {INST_NOP, INST_NOP}
                                          : {(word + 1) ^ MEM_PATTERN, word ^ MEM_PATTERN};
        exp_miss  = (exp_exc == EXC_NONE) && (unc || hit_way < 0);
        exp_maddr = unc ? {addr[31:3], 3'b000} : {addr[31:6], 6'b000000};
        exp_mlen  = unc ? 8'd1 : 8'd15;
        if (exp_exc == EXC_NONE && !unc) begin
            if (hit_way >= 0) begin
                m_lru[idx] = (hit_way == 0);
            end else begin
                victim               = m_lru[idx];
                m_valid[victim][idx] = 1'b1;
                m_tag[victim][idx]   = tg;
                m_lru[idx]           = !victim;
            end
        end
    endtask

    // store tag writes an invalid entry, like an index invalidate
    task automatic apply_cacop(input logic [31:0] addr, input cacop_code_e code);
        index_t idx;
        idx = addr[11:6];
        if (code == HIT_INVALIDATE) begin
            for (int w = 0; w < NUM_WAYS; w++) begin
                if (m_valid[w][idx] && m_tag[w][idx] == addr[31:12]) begin
                    m_valid[w][idx] = 1'b0;
                end
            end
        end else begin
            m_valid[addr[0]][idx] = 1'b0;
        end
    endtask

    always @(posedge clk) begin
        if (!rstn) begin
            for (int s = 0; s < SET_NUM; s++) begin
                m_valid[0][s] = 1'b0;
                m_valid[1][s] = 1'b0;
                m_lru[s]      = 1'b0;
            end
            fetch_pending = 1'b0;
            cacop_pending = 1'b0;
            cacop_busy    = 1'b0;
            if (i_rready === 1'b1 || i_mem_rvalid === 1'b1 ||
                i_cacop_ready === 1'b1 || i_cacop_complete === 1'b1) begin
                report_failure("a handshake output is high during reset");
            end
        end else begin
            // busy while a fetch is outstanding or an operation is in its cacop cycle
            exp_idle   = !fetch_pending && !cacop_busy;
            cacop_busy = 1'b0;
            compare_value("o_idle", exp_idle, i_idle);
            if (fetch_pending) begin
                wait_cycles++;
            end
            if (i_mem_rvalid) begin
                if (!fetch_pending || !exp_miss) begin
                    report_failure("memory request where the model predicts none");
                end else if (!mem_seen) begin
                    compare_value("o_mem_raddr", exp_maddr, i_mem_raddr);
                    compare_value("o_mem_rlen", exp_mlen, i_mem_rlen);
                    mem_seen = 1'b1;
                end
            end
            if (i_rready) begin
                if (!fetch_pending) begin
                    report_failure("o_rready pulsed with no fetch outstanding");
                end else begin
                    compare_value("o_rdata", exp_rdata, i_rdata);
                    compare_value("o_exception", exp_exc, i_exception);
                    compare_value("o_badv", exp_badv, i_badv);
                    if (!exp_miss && wait_cycles != 1) begin
                        report_failure($sformatf("hit answered after %0d cycles", wait_cycles));
                    end
                    if (exp_miss && !mem_seen) begin
                        report_failure("predicted miss completed without a memory request");
                    end
                    fetch_pending = 1'b0;
                end
            end
            if (i_cacop_complete) begin
                if (!cacop_pending) begin
                    report_failure("o_cacop_complete pulsed with no operation outstanding");
                end
                cacop_pending = 1'b0;
            end
            if (exp_idle && i_cacop_en) begin
                if (!i_cacop_ready) begin
                    report_failure("o_cacop_ready stayed low when an operation was accepted");
                end
                apply_cacop(i_raddr, i_cacop_code);
                cacop_pending = 1'b1;
                cacop_busy    = 1'b1;
            end else begin
                if (i_cacop_ready) begin
                    report_failure("o_cacop_ready pulsed with no operation accepted");
                end
                if (exp_idle && i_rvalid) begin
                    predict_fetch(i_raddr, i_uncache);
                    fetch_pending = 1'b1;
                    mem_seen      = 1'b0;
                    wait_cycles   = 0;
                end
            end
        end
    end

endmodule

// File: sim/tb_icache.sv
`timescale 1ns/100ps

module tb_icache
    import icache_geom_pkg::*;
    import icache_ops_pkg::*;
();

    localparam logic [31:0] MEM_PATTERN   = 32'h5a3c_96e1;
    localparam int          FETCH_TIMEOUT = 40;
    localparam int          CACOP_TIMEOUT = 10;
    localparam int          NUM_RANDOM    = 400;

    logic        clk;
    logic        rstn;
    logic        i_rvalid;
    logic [31:0] i_raddr;
    logic        i_uncache;
    logic        o_rready;
    fetch_t      o_rdata;
    exc_code_t   o_exception;
    logic [31:0] o_badv;
    logic        o_idle;
    logic        o_mem_rvalid;
    logic [31:0] o_mem_raddr;
    logic [7:0]  o_mem_rlen;
    logic        i_mem_rready;
    line_t       i_mem_rdata;
    logic        i_cacop_en;
    cacop_code_e i_cacop_code;
    logic        o_cacop_ready;
    logic        o_cacop_complete;

    integer      seed;
    int          timeouts;
    int          check_errors;
    int          checks;
    tag_t        tag_pool [4];
    index_t      index_pool [3];

    icache dut_i (.*);

    icache_checker #(.MEM_PATTERN(MEM_PATTERN)) checker_i (
        .clk              (clk),
        .rstn             (rstn),
        .i_rvalid         (i_rvalid),
        .i_raddr          (i_raddr),
        .i_uncache        (i_uncache),
        .i_cacop_en       (i_cacop_en),
        .i_cacop_code     (i_cacop_code),
        .i_rready         (o_rready),
        .i_rdata          (o_rdata),
        .i_exception      (o_exception),
        .i_badv           (o_badv),
        .i_idle           (o_idle),
        .i_mem_rvalid     (o_mem_rvalid),
        .i_mem_raddr      (o_mem_raddr),
        .i_mem_rlen       (o_mem_rlen),
        .i_cacop_ready    (o_cacop_ready),
        .i_cacop_complete (o_cacop_complete),
        .o_errors         (check_errors),
        .o_checks         (checks)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // each memory word holds its word address xor the pattern
    function automatic line_t mem_line(input logic [31:0] base);
        line_t data;
        for (int i = 0; i < LINE_BITS / 32; i++) begin
            data[i*32 +: 32] = ((base >> 2) + i) ^ MEM_PATTERN;
        end
        return data;
    endfunction

    function automatic logic [31:0] pick_addr();
        tag_t       tg;
        index_t     idx;
        logic [5:0] off;
        tg  = tag_pool[$unsigned($random(seed)) % 4];
        idx = index_pool[$unsigned($random(seed)) % 3];
        off = 6'($random(seed));
        return {tg, idx, off[5:2], 2'b00};
    endfunction

    task automatic fetch(input logic [31:0] addr, input logic unc);
        int n;
        if (timeouts != 0) begin
            return;
        end
        @(negedge clk);
        i_rvalid  = 1'b1;
        i_raddr   = addr;
        i_uncache = unc;
        n = 0;
        do begin
            @(negedge clk);
            n++;
        end while (!o_rready && n < FETCH_TIMEOUT);
        i_rvalid  = 1'b0;
        i_uncache = 1'b0;
        if (!o_rready) begin
            $display("fetch of %h got no o_rready within %0d cycles", addr, FETCH_TIMEOUT);
            timeouts++;
        end
    endtask

    task automatic cache_op(input logic [31:0] addr, input cacop_code_e code);
        int n;
        if (timeouts != 0) begin
            return;
        end
        @(negedge clk);
        i_cacop_en   = 1'b1;
        i_cacop_code = code;
        i_raddr      = addr;
        n = 0;
        do begin
            @(negedge clk);
            n++;
        end while (o_idle && n < CACOP_TIMEOUT);
        i_cacop_en = 1'b0;
        if (o_idle) begin
            $display("cache operation on %h was never accepted", addr);
            timeouts++;
        end
        n = 0;
        while (!o_cacop_complete && n < CACOP_TIMEOUT) begin
            @(negedge clk);
            n++;
        end
        if (!o_cacop_complete) begin
            $display("cache operation on %h never signalled completion", addr);
            timeouts++;
        end
    endtask

    // memory answers after 1 to 6 cycles
    initial begin
        int delay;
        i_mem_rready = 1'b0;
        i_mem_rdata  = '0;
        forever begin
            @(negedge clk);
            if (o_mem_rvalid) begin
                delay = 1 + $unsigned($random(seed)) % 6;
                repeat (delay - 1) @(negedge clk);
                i_mem_rdata  = mem_line(o_mem_raddr);
                i_mem_rready = 1'b1;
                @(negedge clk);
                i_mem_rready = 1'b0;
            end
        end
    end

    initial begin
        int          sel;
        logic [31:0] addr;
        seed         = 32'h0d99_4f53;
        timeouts     = 0;
        rstn         = 1'b0;
        i_rvalid     = 1'b0;
        i_raddr      = '0;
        i_uncache    = 1'b0;
        i_cacop_en   = 1'b0;
        i_cacop_code = STORE_TAG;
        tag_pool     = '{20'h1_2345, 20'h0_00a7, 20'h8_0f00, 20'hf_ffc1};
        index_pool   = '{6'd5, 6'd17, 6'd63};
        repeat (10) @(negedge clk);
        rstn = 1'b1;

        // set 5 fills, first tag refreshed, third tag evicts the second
        fetch({tag_pool[0], 6'd5, 6'h08}, 1'b0);
        fetch({tag_pool[0], 6'd5, 6'h10}, 1'b0);
        fetch({tag_pool[1], 6'd5, 6'h00}, 1'b0);
        fetch({tag_pool[0], 6'd5, 6'h38}, 1'b0);
        fetch({tag_pool[2], 6'd5, 6'h04}, 1'b0);
        fetch({tag_pool[0], 6'd5, 6'h20}, 1'b0);
        fetch({tag_pool[1], 6'd5, 6'h00}, 1'b0);

        // uncached read leaves the line absent
        fetch({tag_pool[3], 6'd17, 6'h2c}, 1'b1);
        fetch({tag_pool[3], 6'd17, 6'h2c}, 1'b0);

        fetch({tag_pool[0], 6'd5, 6'h0a}, 1'b0);
        fetch({tag_pool[2], 6'd63, 6'h13}, 1'b1);

        fetch({tag_pool[0], 6'd17, 6'h18}, 1'b0);
        fetch({tag_pool[0], 6'd17, 6'h18}, 1'b0);
        cache_op({tag_pool[0], 6'd17, 6'h00}, HIT_INVALIDATE);
        fetch({tag_pool[0], 6'd17, 6'h18}, 1'b0);
        // clear both ways of set 5
        cache_op({tag_pool[0], 6'd5, 6'h00}, INDEX_INVALIDATE);
        cache_op({tag_pool[0], 6'd5, 6'h01}, INDEX_INVALIDATE);
        fetch({tag_pool[0], 6'd5, 6'h20}, 1'b0);

        for (int i = 0; i < NUM_RANDOM; i++) begin
            sel  = $unsigned($random(seed)) % 100;
            addr = pick_addr();
            if (sel < 70) begin
                fetch(addr, 1'b0);
            end else if (sel < 80) begin
                fetch(addr, 1'b1);
            end else if (sel < 88) begin
                fetch(addr | 32'(sel % 3 + 1), sel[0]);
            end else begin
                cache_op(addr | 32'(sel & 1), cacop_code_e'($unsigned($random(seed)) % 3));
            end
        end

        repeat (3) @(negedge clk);
        $display("checks %0d, check errors %0d, timeouts %0d", checks, check_errors, timeouts);
        if (check_errors == 0 && timeouts == 0 && checks > 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

// File: flist.f
src/icache_geom_pkg.sv
src/icache_ops_pkg.sv
src/icache_way.sv
src/icache_ctrl.sv
src/icache_out_select.sv
src/icache.sv
sim/icache_checker.sv
sim/tb_icache.sv

// File: Bender.yml
package:
  name: icache

sources:
  - src/icache_geom_pkg.sv
  - src/icache_ops_pkg.sv
  - src/icache_way.sv
  - src/icache_ctrl.sv
  - src/icache_out_select.sv
  - src/icache.sv
  - target: simulation
    files:
      - sim/icache_checker.sv
      - sim/tb_icache.sv
